/* source/display_pkg.sv */
`default_nettype none

package display_pkg;

    localparam int DIGIT_COUNT = 4;
    localparam int SCAN_BITS   = $clog2(DIGIT_COUNT);  // digit select width

    typedef logic [3:0]             nibble_t;     // one hex digit
    typedef logic [7:0]             seg_t;        // {dp, g, f, e, d, c, b, a}, active low
    typedef logic [DIGIT_COUNT-1:0] digit_sel_t;  // digit enables, active low

    localparam logic DP_OFF = 1'b1;               // decimal point is never lit

    // segment patterns for 0..F
    localparam seg_t HEX_SEGMENTS [16] = '{
        {DP_OFF, 7'b100_0000},  // 0
        {DP_OFF, 7'b111_1001},  // 1
        {DP_OFF, 7'b010_0100},  // 2
        {DP_OFF, 7'b011_0000},  // 3
        {DP_OFF, 7'b001_1001},  // 4
        {DP_OFF, 7'b001_0010},  // 5
        {DP_OFF, 7'b000_0010},  // 6
        {DP_OFF, 7'b111_1000},  // 7
        {DP_OFF, 7'b000_0000},  // 8
        {DP_OFF, 7'b001_0000},  // 9
        {DP_OFF, 7'b000_1000},  // A
        {DP_OFF, 7'b000_0011},  // b
        {DP_OFF, 7'b100_0110},  // C
        {DP_OFF, 7'b010_0001},  // d
        {DP_OFF, 7'b000_0110},  // E
        {DP_OFF, 7'b000_1110}   // F
    };

endpackage

`default_nettype wire

/* source/seg_display.sv */
`timescale 1ns/10ps
`default_nettype none

module seg_display #(
    parameter int REFRESH_WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rx_done,
    input  uart_pkg::data_t         data,
    output display_pkg::seg_t       seg,
    output display_pkg::digit_sel_t digit
);
    import uart_pkg::*;
    import display_pkg::*;

    data_t                    shown_q;  // last good byte
    data_t                    count_q;  // good frames, wraps at 256
    logic [REFRESH_WIDTH-1:0] refresh_cnt;
    logic [SCAN_BITS-1:0]     scan_sel;
    nibble_t                  nibble;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shown_q <= '0;
            count_q <= '0;
        end else if (rx_done) begin
            shown_q <= data;
            count_q <= count_q + 1'b1;
        end
    end

    // free-running scan counter, top bits pick the digit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            refresh_cnt <= '0;
        else
            refresh_cnt <= refresh_cnt + 1'b1;
    end

    assign scan_sel = refresh_cnt[REFRESH_WIDTH-1 -: SCAN_BITS];

    always_comb begin
        case (scan_sel)
            2'd0:    nibble = shown_q[3:0];  // rightmost digit
            2'd1:    nibble = shown_q[7:4];
            2'd2:    nibble = count_q[3:0];
            default: nibble = count_q[7:4];
        endcase
    end

    assign seg   = HEX_SEGMENTS[nibble];
    assign digit = ~(digit_sel_t'(1) << scan_sel);  // one enable low at a time

endmodule

`default_nettype wire

/* source/uart_baud.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_baud #(
    parameter int          CNT_WIDTH = 24,
    parameter int unsigned CNT_INC   = 1611
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    logic [CNT_WIDTH-1:0] acc;
    logic [CNT_WIDTH:0]   acc_sum;  // one extra bit holds the carry

    // phase accumulator, average tick rate is clk * CNT_INC / 2^CNT_WIDTH
    assign acc_sum = {1'b0, acc} + (CNT_WIDTH + 1)'(CNT_INC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc  <= '0;
            tick <= 1'b0;
        end else begin
            acc  <= acc_sum[CNT_WIDTH-1:0];  // remainder is kept, so no drift
            tick <= acc_sum[CNT_WIDTH];      // one-clock pulse on carry-out
        end
    end

endmodule

`default_nettype wire

/* source/uart_echo_top.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_echo_top #(
    parameter int          CNT_WIDTH     = 24,
    parameter int unsigned CNT_INC       = 1611,  // about 600 baud x16 at 100 MHz
    parameter int          REFRESH_WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rx,
    output logic                    tx,
    output display_pkg::seg_t       seg,
    output display_pkg::digit_sel_t digit
);
    import uart_pkg::*;

    logic  tick;
    logic  rx_done;
    data_t rx_data;

    uart_baud #(
        .CNT_WIDTH (CNT_WIDTH),
        .CNT_INC   (CNT_INC)
    ) uart_baud_i (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    uart_rx uart_rx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .rx      (rx),
        .data    (rx_data),
        .rx_done (rx_done)
    );

    // every good byte goes straight back out
    uart_tx uart_tx_i (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .start (rx_done),
        .data  (rx_data),
        .tx    (tx)
    );

    seg_display #(
        .REFRESH_WIDTH (REFRESH_WIDTH)
    ) seg_display_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_done (rx_done),
        .data    (rx_data),
        .seg     (seg),
        .digit   (digit)
    );

endmodule

`default_nettype wire

/* source/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // frame layout, 8N1 with 16x oversampling
    localparam int OVERSAMPLE = 16;             // ticks per bit
    localparam int DATA_BITS  = 8;
    localparam int HALF_BIT   = OVERSAMPLE / 2; // start bit is confirmed here

    // idle level of the serial line
    localparam logic LINE_IDLE = 1'b1;

    typedef logic [DATA_BITS-1:0] data_t;       // one serial byte
    typedef logic [3:0]           tick_cnt_t;   // ticks within one bit
    typedef logic [3:0]           bit_cnt_t;    // bits within one frame

    // compare values for the counters
    localparam tick_cnt_t LAST_TICK = tick_cnt_t'(OVERSAMPLE - 1);
    localparam tick_cnt_t MID_TICK  = tick_cnt_t'(HALF_BIT - 1);
    localparam bit_cnt_t  LAST_BIT  = bit_cnt_t'(DATA_BITS - 1);

endpackage

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tick,
    input  logic            rx,
    output uart_pkg::data_t data,
    output logic            rx_done
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t state;
    tick_cnt_t tick_cnt;
    bit_cnt_t  bit_cnt;
    data_t     shift_q;
    logic      rx_meta;
    logic      rx_sync;
    logic      sample_data;
    logic      stop_ok;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= LINE_IDLE;
            rx_sync <= LINE_IDLE;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign sample_data = tick && (state == st_data) && (tick_cnt == LAST_TICK);
    assign stop_ok     = tick && (state == st_stop) && (tick_cnt == LAST_TICK) && rx_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_done  <= 1'b0;
        end else begin
            rx_done <= stop_ok;  // good frames only
            if (tick) begin
                case (state)
                    st_idle: begin
                        tick_cnt <= '0;
                        if (!rx_sync)
                            state <= st_start;  // falling edge of start bit
                    end
                    st_start: begin
                        if (tick_cnt == MID_TICK) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            // a short glitch is high again at mid-bit
                            state    <= rx_sync ? st_idle : st_data;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    st_data: begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            bit_cnt  <= bit_cnt + 1'b1;
                            if (bit_cnt == LAST_BIT)
                                state <= st_stop;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    st_stop: begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            state    <= st_idle;  // low stop bit just drops the frame
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // data arrives lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (sample_data)
            shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
        if (stop_ok)
            data <= shift_q;
    end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tick,
    input  logic            start,
    input  uart_pkg::data_t data,
    output logic            tx
);
    import uart_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } tx_state_t;

    tx_state_t state;
    tick_cnt_t tick_cnt;
    bit_cnt_t  bit_cnt;
    data_t     hold_q;   // byte waiting for the shifter
    data_t     shift_q;
    logic      pending;
    logic      bit_end;
    logic      load;

    assign bit_end = tick && (tick_cnt == LAST_TICK);

    // next frame may follow the stop bit directly
    assign load = tick && pending && ((state == st_idle) || ((state == st_stop) && bit_end));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pending <= 1'b0;
        else if (start)
            pending <= 1'b1;  // a new strobe wins over a load in the same clock
        else if (load)
            pending <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (start)
            hold_q <= data;
        if (load)
            shift_q <= hold_q;
        else if (bit_end && (state == st_data))
            shift_q <= shift_q >> 1;  // bit 0 is always the one on the line
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= LINE_IDLE;
        end else if (load) begin
            state    <= st_start;
            tick_cnt <= '0;
            tx       <= 1'b0;  // start bit
        end else if (tick) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            case (state)
                st_start: begin
                    if (bit_end) begin
                        state   <= st_data;
                        bit_cnt <= '0;
                        tx      <= shift_q[0];
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        if (bit_cnt == LAST_BIT) begin
                            state <= st_stop;
                            tx    <= LINE_IDLE;  // stop bit
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shift_q[1];  // next bit before the shift lands
                        end
                    end
                end
                st_stop: begin
                    if (bit_end)
                        state <= st_idle;
                end
                default: begin
                    state    <= st_idle;
                    tick_cnt <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb/uart_echo_golden.txt */
# name, byte (hex, RAND, NONE or GLITCH), stop bit, idle bits, echo flag,
# then segments for digits 3 2 1 0 in hex, where - is looked up in the table
table c0 f9 a4 b0 99 92 82 f8 80 90 88 83 c6 a1 86 8e
reset_idle  NONE    1  4  0  c0 c0 c0 c0
byte_a5     a5      1  2  1  c0 f9 88 92
byte_3c     3c      1  2  1  c0 a4 b0 c6
bad_stop    e7      0  2  0  c0 a4 b0 c6
after_bad   0f      1  2  1  c0 b0 c0 8e
glitch      GLITCH  1  4  0  c0 b0 c0 8e
rand_0      RAND    1  0  1  -  -  -  -
rand_1      RAND    1  0  1  -  -  -  -
rand_2      RAND    1  0  1  -  -  -  -
rand_3      RAND    1  0  1  -  -  -  -
rand_4      RAND    1  2  1  -  -  -  -
final_5a    5a      1  4  1  c0 90 92 88

/* tb/uart_echo_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_echo_tb;
    import uart_pkg::*;
    import display_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int BIT_CLKS    = 64;       // 16 ticks of 4 clocks each
    localparam int MAX_TESTS   = 32;
    localparam int TOK_BITS    = 8 * 16;   // up to 16 characters per token
    localparam int KIND_BYTE   = 0;
    localparam int KIND_RAND   = 1;
    localparam int KIND_NONE   = 2;
    localparam int KIND_GLITCH = 3;

    logic       clk;
    logic       rst_n;
    logic       rx;
    logic       tx;
    seg_t       seg;
    digit_sel_t digit;

    logic [TOK_BITS-1:0] test_name [MAX_TESTS];
    int                  kind [MAX_TESTS];
    data_t               test_byte [MAX_TESTS];
    logic                stop_val [MAX_TESTS];
    int                  idle_bits [MAX_TESTS];
    logic                echo_flag [MAX_TESTS];
    logic [31:0]         file_pat [MAX_TESTS];     // {d3, d2, d1, d0}
    logic [3:0]          derive_mask [MAX_TESTS];  // digits taken from the table
    int                  test_errors [MAX_TESTS];
    int                  parts_left [MAX_TESTS];
    seg_t                seg_table [16];
    int                  num_tests;
    int                  error_count;
    int                  failed_tests;
    int                  done_tests;
    int                  cycle_count;
    int                  cycle_limit;
    logic [31:0]         lfsr;
    data_t               echo_bytes [$];
    int                  echo_tests [$];
    logic [31:0]         check_words [$];
    int                  check_tests [$];

    uart_echo_top #(
        .CNT_WIDTH     (8),
        .CNT_INC       (64),
        .REFRESH_WIDTH (6)
    ) uart_echo_top_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .tx    (tx),
        .seg   (seg),
        .digit (digit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic int hex_value(input logic [TOK_BITS-1:0] tok);
        int         value;
        int         i;
        logic [7:0] c;
        value = 0;
        for (i = TOK_BITS / 8 - 1; i >= 0; i--) begin
            c = tok[i*8 +: 8];
            if (c >= "0" && c <= "9")
                value = value * 16 + (c - "0");
            else if (c >= "a" && c <= "f")
                value = value * 16 + (c - "a" + 10);
            else if (c >= "A" && c <= "F")
                value = value * 16 + (c - "A" + 10);
        end
        return value;
    endfunction

    // low pair shows the byte, high pair the good-frame count
    function automatic logic [31:0] expected_segments(input int idx, input data_t shown,
                                                      input data_t count);
        logic [15:0] nibbles;
        logic [31:0] word;
        int          d;
        nibbles = {count, shown};
        word    = file_pat[idx];
        for (d = 0; d < 4; d++) begin
            if (derive_mask[idx][d])
                word[d*8 +: 8] = seg_table[nibbles[d*4 +: 4]];
        end
        return word;
    endfunction

    task automatic note_error(input int idx);
        test_errors[idx]++;
        error_count++;
    endtask

    task automatic finish_part(input int idx);
        parts_left[idx]--;
        if (parts_left[idx] == 0) begin
            done_tests++;
            if (test_errors[idx] == 0) begin
                $display("test %0s: ok", test_name[idx]);
            end else begin
                failed_tests++;
                $display("test %0s: %0d error(s)", test_name[idx], test_errors[idx]);
            end
        end
    endtask

    task automatic send_bit(input logic value);
        rx <= value;
        repeat (BIT_CLKS) @(posedge clk);
    endtask

    task automatic send_frame(input data_t value, input logic stop);
        int i;
        send_bit(1'b0);
        for (i = 0; i < DATA_BITS; i++)
            send_bit(value[i]);  // lsb first
        send_bit(stop);
    endtask

    task automatic send_glitch();
        rx <= 1'b0;
        repeat (BIT_CLKS / 4) @(posedge clk);  // a quarter bit, well short of mid-bit
        rx <= 1'b1;
        repeat (10 * BIT_CLKS - BIT_CLKS / 4) @(posedge clk);  // rest of one frame time
    endtask

    // one full scan of the four digits
    task automatic check_display(input int idx, input logic [31:0] expected);
        logic [3:0] seen;
        logic [3:0] bad;
        int         pos;
        seen = '0;
        bad  = '0;
        repeat (BIT_CLKS) begin
            @(negedge clk);
            case (digit)
                4'b1110: pos = 0;
                4'b1101: pos = 1;
                4'b1011: pos = 2;
                4'b0111: pos = 3;
                default: pos = -1;
            endcase
            assert (pos >= 0) else begin
                $display("test %0s: digit enables %b do not select one digit",
                         test_name[idx], digit);
                note_error(idx);
            end
            if (pos >= 0) begin
                seen[pos] = 1'b1;
                assert (bad[pos] || seg === expected[pos*8 +: 8]) else begin
                    $display("FAIL %0s digit %0d: expected %h, actual %h", test_name[idx],
                             pos, expected[pos*8 +: 8], seg);
                    bad[pos] = 1'b1;
                    note_error(idx);
                end
            end
        end
        assert (seen == 4'hf) else begin
            $display("test %0s: not every digit was enabled during one scan", test_name[idx]);
            note_error(idx);
        end
        finish_part(idx);
    endtask

    task automatic read_golden();
        int                  fd;
        int                  code;
        int                  c;
        int                  i;
        int                  stop_i;
        int                  idle_i;
        int                  echo_i;
        logic [TOK_BITS-1:0] tok;
        logic [TOK_BITS-1:0] byte_tok;
        logic [TOK_BITS-1:0] pat_tok;
        fd = $fopen("tb/uart_echo_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file tb/uart_echo_golden.txt");
            return;
        end
        while (num_tests < MAX_TESTS) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1)
                break;
            if (tok == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1)
                    c = $fgetc(fd);
            end else if (tok == "table") begin
                for (i = 0; i < 16; i++)
                    code = $fscanf(fd, "%h", seg_table[i]);
            end else begin
                code = $fscanf(fd, "%s %d %d %d", byte_tok, stop_i, idle_i, echo_i);
                test_name[num_tests]   = tok;
                stop_val[num_tests]    = stop_i[0];
                idle_bits[num_tests]   = idle_i;
                echo_flag[num_tests]   = echo_i[0];
                file_pat[num_tests]    = '0;
                derive_mask[num_tests] = '0;
                test_byte[num_tests]   = '0;
                if (byte_tok == "RAND")
                    kind[num_tests] = KIND_RAND;
                else if (byte_tok == "NONE")
                    kind[num_tests] = KIND_NONE;
                else if (byte_tok == "GLITCH")
                    kind[num_tests] = KIND_GLITCH;
                else begin
                    kind[num_tests]      = KIND_BYTE;
                    test_byte[num_tests] = data_t'(hex_value(byte_tok));
                end
                for (i = 3; i >= 0; i--) begin
                    code = $fscanf(fd, "%s", pat_tok);
                    if (pat_tok == "-")
                        derive_mask[num_tests][i] = 1'b1;
                    else
                        file_pat[num_tests][i*8 +: 8] = seg_t'(hex_value(pat_tok));
                end
                cycle_limit += BIT_CLKS * (10 + idle_i);
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    initial begin : stimulus
        int    idx;
        int    b;
        data_t frame_byte;
        data_t shown;
        data_t count;
        rst_n = 1'b0;
        rx    = 1'b1;
        lfsr  = 32'h1fd7;
        shown = '0;
        count = '0;
        read_golden();
        if (num_tests == 0) begin
            $display("no tests could be read from the golden file");
            $display("Done: errors found");
        end else begin
            cycle_limit += 2000;
            repeat (5) @(posedge clk);
            rst_n <= 1'b1;
            for (idx = 0; idx < num_tests; idx++) begin
                frame_byte = test_byte[idx];
                if (kind[idx] == KIND_RAND) begin
                    for (b = 0; b < DATA_BITS; b++) begin
                        lfsr          = lfsr_next(lfsr);
                        frame_byte[b] = lfsr[0];
                    end
                end
                parts_left[idx] = echo_flag[idx] ? 2 : 1;
                if (echo_flag[idx]) begin
                    echo_bytes.push_back(frame_byte);
                    echo_tests.push_back(idx);
                    shown = frame_byte;  // good frame updates the model
                    count = count + 1'b1;
                end
                if (kind[idx] == KIND_GLITCH)
                    send_glitch();
                else if (kind[idx] != KIND_NONE)
                    send_frame(frame_byte, stop_val[idx]);
                check_words.push_back(expected_segments(idx, shown, count));
                check_tests.push_back(idx);
                repeat (idle_bits[idx]) send_bit(1'b1);
            end
            while (done_tests < num_tests)
                @(posedge clk);
            $display("%0d tests, %0d failed, %0d errors", num_tests, failed_tests, error_count);
            if (error_count == 0)
                $display("Done: no errors");
            else
                $display("Done: errors found");
        end
        $finish;
    end

    initial begin : display_checker
        int          idx;
        logic [31:0] expected;
        forever begin
            @(negedge clk);
            if (check_tests.size() > 0) begin
                idx      = check_tests.pop_front();
                expected = check_words.pop_front();
                check_display(idx, expected);
            end
        end
    end

    initial begin : echo_monitor
        int    i;
        int    idx;
        data_t got;
        data_t want;
        logic  start_ok;
        logic  stop_ok;
        @(posedge rst_n);
        @(negedge clk);
        assert (tx === 1'b1) else begin
            $display("tx is not idle high after reset");
            error_count++;
        end
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                repeat (BIT_CLKS / 2) @(negedge clk);  // centre of the start bit
                start_ok = (tx === 1'b0);
                for (i = 0; i < DATA_BITS; i++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    got[i] = tx;
                end
                repeat (BIT_CLKS) @(negedge clk);
                stop_ok = (tx === 1'b1);
                assert (echo_tests.size() > 0) else begin
                    $display("tx sent a frame with byte %h that no test expected", got);
                    error_count++;
                end
                if (echo_tests.size() > 0) begin
                    idx  = echo_tests.pop_front();
                    want = echo_bytes.pop_front();
                    assert (start_ok) else begin
                        $display("test %0s: echo start bit was not low", test_name[idx]);
                        note_error(idx);
                    end
                    assert (got === want) else begin
                        $display("FAIL %0s echo: expected %h, actual %h", test_name[idx],
                                 want, got);
                        note_error(idx);
                    end
                    assert (stop_ok) else begin
                        $display("test %0s: echo stop bit was not high", test_name[idx]);
                        note_error(idx);
                    end
                    finish_part(idx);
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the echo never arrived", cycle_count);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* uart_echo.f */
source/uart_pkg.sv
source/display_pkg.sv
source/uart_baud.sv
source/uart_rx.sv
source/uart_tx.sv
source/seg_display.sv
source/uart_echo_top.sv
tb/uart_echo_tb.sv
